// ==== Bender.yml ====
package:
  name: apr_core

sources:
  - source/apr_word_pkg.sv
  - source/apr_bus_pkg.sv
  - source/key_sequencer.sv
  - source/ma_relocate.sv
  - source/ar_mb_regs.sv
  - source/mem_ctrl.sv
  - source/pi_chain.sv
  - source/apr_core.sv
  - target: test
    files:
      - test/membus_model.sv
      - test/apr_tb.sv

// ==== all.f ====
source/apr_word_pkg.sv
source/apr_bus_pkg.sv
source/key_sequencer.sv
source/ma_relocate.sv
source/ar_mb_regs.sv
source/mem_ctrl.sv
source/pi_chain.sv
source/apr_core.sv
test/membus_model.sv
test/apr_tb.sv

// ==== source/apr_bus_pkg.sv ====
package apr_bus_pkg;

	// Cycles without acknowledge before non-existent memory
	localparam int NXM_TIMEOUT = 32;
	localparam int NXM_CNT_BITS = $clog2(NXM_TIMEOUT);

	typedef struct packed {
		logic rq_cyc;
		logic rd_rq;
		logic wr_rq;
		logic wr_rs;
		logic fmc_select;
		apr_word_pkg::addr_t addr; // Physical
		apr_word_pkg::word_t mb_out;
	} membus_req_t;

	typedef struct packed {
		logic addr_ack;
		logic rd_rs;
		apr_word_pkg::word_t mb_in;
	} membus_rsp_t;

	// One-cycle strobes from the key sequence
	typedef struct packed {
		logic ma_clr;
		logic ma_inc;
		logic ma_fm_mas;
		logic ar_clr;
		logic ar_fm_datasw;
		logic mb_fm_ar;
		logic mc_rd;
		logic mc_wr;
	} key_strobe_t;

	typedef struct packed {
		logic set;
		apr_word_pkg::word_t iob;
	} pi_cono_t;

	typedef enum logic [2:0] {KT_IDLE, KT1, KT2, KT3, KT_WAIT} key_state_t;

endpackage

// ==== source/apr_core.sv ====
module apr_core (
	input  logic clk,
	input  logic pi_reset,
	input  logic key_ex,
	input  logic key_ex_nxt,
	input  logic key_dep,
	input  logic key_dep_nxt,
	input  logic key_apr_load,
	input  logic sw_user,
	input  logic sw_mem_disable,
	input  apr_word_pkg::word_t datasw,
	input  apr_word_pkg::addr_t mas,
	input  apr_bus_pkg::membus_rsp_t membus_rsp,
	output apr_bus_pkg::membus_req_t membus_req,
	input  apr_word_pkg::chan_t iobus_pi_req,
	input  apr_bus_pkg::pi_cono_t pi_cono,
	input  logic pi_grant,
	input  logic pi_dismiss,
	output apr_word_pkg::word_t ar,
	output apr_word_pkg::word_t mb,
	output apr_word_pkg::addr_t ma,
	output apr_word_pkg::page_t pr,
	output apr_word_pkg::page_t rlr,
	output logic busy,
	output logic nxm,
	output logic illeg_flag,
	output apr_word_pkg::chan_t pih,
	output apr_word_pkg::chan_t pir,
	output apr_word_pkg::chan_t pio,
	output logic pi_active,
	output apr_word_pkg::chan_num_t pi_rq_chan
);

	apr_bus_pkg::key_strobe_t strobe;
	apr_word_pkg::addr_t phys_addr;
	logic illeg;
	logic fmc_select;
	logic mc_done;
	logic mb_clr;
	logic mb_fm_bus;

	key_sequencer key_seq_i (.clk, .pi_reset, .key_ex, .key_ex_nxt, .key_dep,
		.key_dep_nxt, .mc_done, .strobe, .busy);

	ma_relocate ma_rel_i (.clk, .pi_reset, .strobe, .mas, .datasw, .key_apr_load,
		.sw_user, .ma, .pr, .rlr, .phys_addr, .illeg, .fmc_select);

	ar_mb_regs ar_mb_i (.clk, .pi_reset, .strobe, .datasw, .mb_clr, .mb_fm_bus,
		.mb_in(membus_rsp.mb_in), .ar, .mb);

	mem_ctrl mem_ctrl_i (.clk, .pi_reset, .strobe, .phys_addr, .illeg, .fmc_select,
		.mb, .sw_mem_disable, .rsp(membus_rsp), .req(membus_req), .mb_clr,
		.mb_fm_bus, .mc_done, .nxm, .illeg_flag);

	pi_chain pi_chain_i (.clk, .pi_reset, .pi_req_in(iobus_pi_req), .cono(pi_cono),
		.pi_grant, .pi_dismiss, .pih, .pir, .pio, .pi_active, .pi_rq_chan);

endmodule

// ==== source/apr_word_pkg.sv ====
package apr_word_pkg;

	// Bit 0 is the most significant bit throughout
	localparam int WORD_BITS = 36;
	localparam int ADDR_BITS = 18;
	localparam int PAGE_BITS = 8;
	localparam int CHAN_BITS = 7;
	localparam int CHAN_NUM_BITS = 3;

	// High address bits that are zero for fast memory (0 to 17 octal)
	localparam int FMC_LIMIT_BITS = 14;

	typedef logic [0:WORD_BITS-1] word_t;

	typedef logic [WORD_BITS-ADDR_BITS:WORD_BITS-1] addr_t; // 18 to 35

	typedef logic [WORD_BITS-ADDR_BITS:WORD_BITS-ADDR_BITS+PAGE_BITS-1] page_t; // 18 to 25

	// Channels 1 to 7 with channel 1 highest priority
	typedef logic [1:CHAN_BITS] chan_t;

	typedef logic [0:CHAN_NUM_BITS-1] chan_num_t; // 0 is no channel

endpackage

// ==== source/ar_mb_regs.sv ====
module ar_mb_regs (
	input  logic clk,
	input  logic pi_reset,
	input  apr_bus_pkg::key_strobe_t strobe,
	input  apr_word_pkg::word_t datasw,
	input  logic mb_clr,
	input  logic mb_fm_bus,
	input  apr_word_pkg::word_t mb_in,
	output apr_word_pkg::word_t ar,
	output apr_word_pkg::word_t mb
);

	always_ff @(posedge clk) begin
		if (pi_reset)
			ar <= '0;
		else if (strobe.ar_clr)
			ar <= '0;
		else if (strobe.ar_fm_datasw)
			ar <= ar | datasw; // Ones transfer
	end

	always_ff @(posedge clk) begin
		if (pi_reset)
			mb <= '0;
		else if (strobe.mb_fm_ar)
			mb <= ar;
		else if (mb_clr)
			mb <= '0;
		else if (mb_fm_bus)
			mb <= mb | mb_in;
	end

endmodule

// ==== source/key_sequencer.sv ====
module key_sequencer (
	input  logic clk,
	input  logic pi_reset,
	input  logic key_ex,
	input  logic key_ex_nxt,
	input  logic key_dep,
	input  logic key_dep_nxt,
	input  logic mc_done,
	output apr_bus_pkg::key_strobe_t strobe,
	output logic busy
);

	apr_bus_pkg::key_state_t state;
	logic key_manual;
	logic key_manual_d;
	logic key_edge;
	logic dep_sel; // Deposit or deposit next
	logic nxt_sel; // One of the next variants

	assign key_manual = key_ex | key_ex_nxt | key_dep | key_dep_nxt;
	assign key_edge = key_manual & ~key_manual_d;
	assign busy = state != apr_bus_pkg::KT_IDLE;

	always_ff @(posedge clk) begin
		if (pi_reset) begin
			state <= apr_bus_pkg::KT_IDLE;
			key_manual_d <= 1'b0;
			dep_sel <= 1'b0;
			nxt_sel <= 1'b0;
		end else begin
			key_manual_d <= key_manual;
			case (state)
				apr_bus_pkg::KT_IDLE: if (key_edge) begin
					dep_sel <= key_dep | key_dep_nxt;
					nxt_sel <= key_ex_nxt | key_dep_nxt;
					state <= apr_bus_pkg::KT1;
				end
				apr_bus_pkg::KT1: state <= apr_bus_pkg::KT2;
				apr_bus_pkg::KT2: state <= apr_bus_pkg::KT3;
				apr_bus_pkg::KT3: state <= apr_bus_pkg::KT_WAIT;
				apr_bus_pkg::KT_WAIT: if (mc_done)
					state <= apr_bus_pkg::KT_IDLE;
				default: state <= apr_bus_pkg::KT_IDLE;
			endcase
		end
	end

	always_comb begin
		strobe = '0;
		case (state)
			apr_bus_pkg::KT1: begin
				strobe.ma_clr = ~nxt_sel;
				strobe.ma_inc = nxt_sel;
				strobe.ar_clr = dep_sel;
			end
			apr_bus_pkg::KT2: begin
				strobe.ma_fm_mas = ~nxt_sel;
				strobe.ar_fm_datasw = dep_sel;
			end
			apr_bus_pkg::KT3: begin
				strobe.mc_rd = ~dep_sel;
				strobe.mb_fm_ar = dep_sel;
				strobe.mc_wr = dep_sel;
			end
			default: ;
		endcase
	end

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (pi_reset)
		!(strobe.mc_rd && strobe.mc_wr))
		else $error("read and write strobes together");

endmodule

// ==== source/ma_relocate.sv ====
module ma_relocate (
	input  logic clk,
	input  logic pi_reset,
	input  apr_bus_pkg::key_strobe_t strobe,
	input  apr_word_pkg::addr_t mas,
	input  apr_word_pkg::word_t datasw,
	input  logic key_apr_load,
	input  logic sw_user,
	output apr_word_pkg::addr_t ma,
	output apr_word_pkg::page_t pr,
	output apr_word_pkg::page_t rlr,
	output apr_word_pkg::addr_t phys_addr,
	output logic illeg,
	output logic fmc_select
);

	apr_word_pkg::page_t ma_page;
	apr_word_pkg::page_t rel_page;
	logic inh_rel;

	always_ff @(posedge clk) begin
		if (strobe.ma_clr)
			ma <= '0;
		else if (strobe.ma_inc)
			ma <= ma + apr_word_pkg::addr_t'(1);
		else if (strobe.ma_fm_mas)
			ma <= ma | mas;
	end

	// Loaded from the data switches only outside a key sequence
	always_ff @(posedge clk) begin
		if (pi_reset) begin
			pr <= '0;
			rlr <= '0;
		end else if (key_apr_load && strobe == '0) begin
			pr <= datasw[0:7];
			rlr <= datasw[18:25];
		end
	end

	assign ma_page = ma[18:25];
	assign fmc_select = ma[18 +: apr_word_pkg::FMC_LIMIT_BITS] == '0; // Fast memory
	assign inh_rel = ~sw_user | fmc_select;

	assign illeg = ~inh_rel & (ma_page > pr);
	assign rel_page = ma_page + (inh_rel ? apr_word_pkg::page_t'(0) : rlr); // Wraps at 256
	assign phys_addr = {rel_page, ma[26:35]};

endmodule

// ==== source/mem_ctrl.sv ====
module mem_ctrl (
	input  logic clk,
	input  logic pi_reset,
	input  apr_bus_pkg::key_strobe_t strobe,
	input  apr_word_pkg::addr_t phys_addr,
	input  logic illeg,
	input  logic fmc_select,
	input  apr_word_pkg::word_t mb,
	input  logic sw_mem_disable,
	input  apr_bus_pkg::membus_rsp_t rsp,
	output apr_bus_pkg::membus_req_t req,
	output logic mb_clr,
	output logic mb_fm_bus,
	output logic mc_done,
	output logic nxm,
	output logic illeg_flag
);

	logic mc_rd;
	logic mc_wr;
	logic mc_rq;
	logic wr_rs_q;
	logic [apr_bus_pkg::NXM_CNT_BITS-1:0] nxm_cnt;
	apr_word_pkg::addr_t addr_q;
	logic fmc_q;
	logic start;
	logic nxm_timeout;
	logic ack;

	assign start = strobe.mc_rd | strobe.mc_wr;
	assign nxm_timeout = mc_rq & ~sw_mem_disable &
		(nxm_cnt == apr_bus_pkg::NXM_CNT_BITS'(apr_bus_pkg::NXM_TIMEOUT - 1));
	assign ack = mc_rq & (rsp.addr_ack | nxm_timeout); // Timeout counts as acknowledge
	assign mb_clr = strobe.mc_rd & ~illeg;
	assign mb_fm_bus = mc_rd & rsp.rd_rs;

	always_ff @(posedge clk) begin
		if (pi_reset) begin
			mc_rd <= 1'b0;
			mc_wr <= 1'b0;
			mc_rq <= 1'b0;
			wr_rs_q <= 1'b0;
			mc_done <= 1'b0;
			nxm <= 1'b0;
			illeg_flag <= 1'b0;
			nxm_cnt <= '0;
		end else begin
			mc_done <= 1'b0;
			wr_rs_q <= ack & mc_wr;
			if (mc_rq)
				nxm_cnt <= nxm_cnt + 1'b1;
			if (start) begin
				nxm <= 1'b0;
				illeg_flag <= illeg;
				nxm_cnt <= '0;
				if (illeg) begin
					mc_done <= 1'b1; // No bus cycle
				end else begin
					mc_rq <= 1'b1;
					mc_rd <= strobe.mc_rd;
					mc_wr <= strobe.mc_wr;
				end
			end
			if (ack)
				mc_rq <= 1'b0;
			if (nxm_timeout) begin
				nxm <= 1'b1;
				if (mc_rd) begin
					mc_rd <= 1'b0; // MB stays cleared
					mc_done <= 1'b1;
				end
			end
			if (mb_fm_bus || wr_rs_q) begin
				mc_rd <= 1'b0;
				mc_wr <= 1'b0;
				mc_done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			addr_q <= phys_addr;
			fmc_q <= fmc_select;
		end
	end

	always_comb begin
		req.rq_cyc = mc_rq;
		req.rd_rq = mc_rd;
		req.wr_rq = mc_wr;
		req.wr_rs = wr_rs_q;
		req.fmc_select = fmc_q;
		req.addr = addr_q;
		req.mb_out = (mc_wr & (ack | wr_rs_q)) ? mb : '0;
	end

	a_rq_excl: assert property (@(posedge clk) disable iff (pi_reset)
		!(req.rd_rq && req.wr_rq))
		else $error("read and write request together");

	a_wr_rs_ack: assert property (@(posedge clk) disable iff (pi_reset)
		$rose(req.wr_rs) |-> ($past(rsp.addr_ack) || nxm))
		else $error("write restart without acknowledge");

endmodule

// ==== source/pi_chain.sv ====
module pi_chain (
	input  logic clk,
	input  logic pi_reset,
	input  apr_word_pkg::chan_t pi_req_in,
	input  apr_bus_pkg::pi_cono_t cono,
	input  logic pi_grant,
	input  logic pi_dismiss,
	output apr_word_pkg::chan_t pih,
	output apr_word_pkg::chan_t pir,
	output apr_word_pkg::chan_t pio,
	output logic pi_active,
	output apr_word_pkg::chan_num_t pi_rq_chan
);

	apr_word_pkg::chan_t pi_req; // One-hot winning channel
	apr_word_pkg::chan_t pih_low; // Lowest held channel
	apr_word_pkg::chan_t pir_next;
	apr_word_pkg::chan_t pih_next;
	logic blocked;
	logic held;

	always_comb begin
		blocked = 1'b0;
		held = 1'b0;
		pi_rq_chan = '0;
		for (int i = 1; i <= apr_word_pkg::CHAN_BITS; i++) begin
			pi_req[i] = pir[i] & ~pih[i] & ~blocked;
			blocked = blocked | pir[i] | pih[i];
			pih_low[i] = pih[i] & ~held;
			held = held | pih[i];
			if (pi_req[i])
				pi_rq_chan = apr_word_pkg::chan_num_t'(i);
		end
	end

	always_comb begin
		pir_next = pir;
		pih_next = pih;
		if (pi_active)
			pir_next = pir_next | (pi_req_in & pio);
		if (pi_grant) begin
			pir_next = pir_next & ~pi_req;
			pih_next = pih_next | pi_req;
		end
		if (pi_dismiss)
			pih_next = pih_next & ~pih_low;
		if (cono.set && cono.iob[23]) begin
			pir_next = '0;
			pih_next = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (pi_reset) begin
			pih <= '0;
			pir <= '0;
			pio <= '0;
			pi_active <= 1'b0;
		end else begin
			pih <= pih_next;
			pir <= pir_next;
			if (cono.set) begin
				pio <= cono.iob[29:35];
				if (cono.iob[27])
					pi_active <= 1'b0;
				if (cono.iob[28])
					pi_active <= 1'b1; // Set wins
			end
		end
	end

	a_grant_req: assert property (@(posedge clk) disable iff (pi_reset)
		pi_grant |-> pi_rq_chan != '0)
		else $error("grant with no channel requesting");

endmodule

// ==== test/apr_tb.sv ====
module apr_tb;

	localparam int NUM_TESTS = 6;
	localparam int WATCHDOG = NUM_TESTS * (2 * apr_bus_pkg::NXM_TIMEOUT + 40);
	localparam int BUSY_LIMIT = 2 * apr_bus_pkg::NXM_TIMEOUT + 20;

	logic clk = 1'b0;
	logic pi_reset;
	logic key_ex, key_ex_nxt, key_dep, key_dep_nxt, key_apr_load;
	logic sw_user, sw_mem_disable, pi_grant, pi_dismiss;
	apr_word_pkg::word_t datasw, ar, mb;
	apr_word_pkg::addr_t mas, ma, last_rq_addr;
	apr_bus_pkg::membus_rsp_t membus_rsp;
	apr_bus_pkg::membus_req_t membus_req;
	apr_word_pkg::chan_t iobus_pi_req, pih, pir, pio;
	apr_bus_pkg::pi_cono_t pi_cono;
	apr_word_pkg::page_t pr, rlr;
	logic busy, nxm, illeg_flag, pi_active;
	apr_word_pkg::chan_num_t pi_rq_chan;

	logic [31:0] rng = 32'h97dd43fc;
	string test_name;
	int errors = 0;
	int err_mark;
	int failed_tests = 0;
	logic chk = 1'b0;
	apr_word_pkg::word_t expv, got;
	logic illeg_test = 1'b0;
	logic fmc_test = 1'b0;
	logic hold_test = 1'b0;

	apr_core dut_i (.*);
	membus_model model_i (.clk, .pi_reset, .req(membus_req), .rsp(membus_rsp));

	always #10 clk = ~clk;

	always @(posedge clk)
		if (membus_req.rq_cyc)
			last_rq_addr <= membus_req.addr; // Physical address actually sent

	a_value: assert property (@(posedge clk) chk |-> got == expv)
		else begin
			$display("MISMATCH %s expected %h actual %h", test_name, expv, got);
			errors++;
		end
	a_no_req: assert property (@(posedge clk) illeg_test |-> !membus_req.rq_cyc)
		else begin
			$display("%s: bus request made for an illegal address", test_name);
			errors++;
		end
	a_fmc: assert property (@(posedge clk) fmc_test && membus_req.rq_cyc
		|-> membus_req.fmc_select)
		else begin
			$display("%s: fast memory select low during request", test_name);
			errors++;
		end
	a_hold: assert property (@(posedge clk) hold_test |-> busy)
		else begin
			$display("%s: busy dropped while memory is disabled", test_name);
			errors++;
		end

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	function automatic apr_word_pkg::word_t rand_word();
		logic [31:0] a;
		logic [31:0] b;
		a = next_rand();
		b = next_rand();
		return {a[3:0], b};
	endfunction

	// Lowest pending channel or 0 when none
	function automatic int lowest_chan(apr_word_pkg::chan_t c);
		for (int i = 1; i <= 7; i++)
			if (c[i])
				return i;
		return 0;
	endfunction

	task automatic step(int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	task automatic check(apr_word_pkg::word_t e, apr_word_pkg::word_t g);
		expv = e;
		got = g;
		chk = 1'b1;
		step(1);
		chk = 1'b0;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < BUSY_LIMIT) begin
			step(1);
			n++;
		end
		if (busy) begin
			$display("%s: busy did not fall after the key sequence", test_name);
			errors++;
		end
	endtask

	task automatic press(int which);
		case (which)
			0: key_ex = 1'b1;
			1: key_ex_nxt = 1'b1;
			2: key_dep = 1'b1;
			default: key_dep_nxt = 1'b1;
		endcase
		step(3);
		{key_ex, key_ex_nxt, key_dep, key_dep_nxt} = '0;
		wait_idle();
	endtask

	task automatic apply_reset();
		pi_reset = 1'b1;
		step(10);
		pi_reset = 1'b0;
	endtask

	task automatic begin_test(string n);
		test_name = n;
		err_mark = errors;
	endtask

	task automatic end_test();
		step(1);
		if (errors == err_mark) begin
			$display("ok     %s", test_name);
		end else begin
			$display("failed %s (%0d errors)", test_name, errors - err_mark);
			failed_tests++;
		end
	endtask

	task automatic cono(logic clr, logic off, logic on, apr_word_pkg::chan_t mask);
		pi_cono.iob = '0;
		pi_cono.iob[23] = clr;
		pi_cono.iob[27] = off;
		pi_cono.iob[28] = on;
		pi_cono.iob[29:35] = mask;
		pi_cono.set = 1'b1;
		step(1);
		pi_cono.set = 1'b0;
	endtask

	task automatic deposit_then_examine();
		apr_word_pkg::addr_t addrs [3];
		apr_word_pkg::word_t words [3];
		logic [31:0] r;
		begin_test("deposit_examine");
		sw_user = 1'b0;
		for (int i = 0; i < 3; i++) begin
			r = next_rand();
			addrs[i] = {1'b0, r[16:0]};
			words[i] = rand_word();
			mas = addrs[i];
			datasw = words[i];
			press(2);
			check(words[i], ar);
		end
		for (int i = 0; i < 3; i++) begin
			mas = addrs[i];
			press(0);
			check(words[i], mb);
		end
		end_test();
	endtask

	task automatic deposit_examine_next();
		apr_word_pkg::addr_t base;
		apr_word_pkg::word_t words [4];
		logic [31:0] r;
		begin_test("next_variants");
		r = next_rand();
		base = {2'b00, r[15:0]};
		for (int i = 0; i < 4; i++) begin
			words[i] = rand_word();
			datasw = words[i];
			mas = base;
			press(i == 0 ? 2 : 3);
			check(apr_word_pkg::word_t'(base + i), apr_word_pkg::word_t'(ma));
			check(words[i], model_i.mem[base + i]);
		end
		for (int i = 0; i < 4; i++) begin
			press(i == 0 ? 0 : 1);
			check(words[i], mb);
		end
		end_test();
	endtask

	task automatic relocate_and_protect();
		logic [31:0] r;
		logic [7:0] prv, rl, pg;
		logic [9:0] lo;
		begin_test("relocation");
		r = next_rand();
		prv = {2'b01, r[5:0]};
		rl = r[15:8];
		datasw = '0;
		datasw[0:7] = prv;
		datasw[18:25] = rl;
		key_apr_load = 1'b1;
		step(1);
		key_apr_load = 1'b0;
		check(apr_word_pkg::word_t'(prv), apr_word_pkg::word_t'(pr));
		check(apr_word_pkg::word_t'(rl), apr_word_pkg::word_t'(rlr));
		sw_user = 1'b1;
		for (int i = 0; i < 2; i++) begin
			r = next_rand();
			pg = 8'd1 + r[7:0] % prv; // 1 up to PR
			lo = r[17:8];
			mas = {pg, lo};
			press(0);
			check(apr_word_pkg::word_t'({8'(pg + rl), lo}),
				apr_word_pkg::word_t'(last_rq_addr));
		end
		for (int i = 0; i < 2; i++) begin
			r = next_rand();
			pg = prv + 8'd1 + r[7:0] % (8'd255 - prv);
			mas = {pg, r[17:8]};
			illeg_test = 1'b1;
			press(0);
			illeg_test = 1'b0;
			check(36'd1, apr_word_pkg::word_t'(illeg_flag));
			check(36'd0, apr_word_pkg::word_t'(busy));
		end
		sw_user = 1'b0;
		end_test();
	endtask

	task automatic fast_memory_bypass();
		logic [31:0] r;
		apr_word_pkg::word_t w;
		begin_test("fast_memory");
		sw_user = 1'b1;
		fmc_test = 1'b1;
		for (int i = 0; i < 2; i++) begin
			r = next_rand();
			mas = apr_word_pkg::addr_t'(r[3:0]); // 0 to 17 octal
			w = rand_word();
			datasw = w;
			press(2);
			check(apr_word_pkg::word_t'(mas), apr_word_pkg::word_t'(last_rq_addr));
			press(0);
			check(w, mb);
		end
		fmc_test = 1'b0;
		sw_user = 1'b0;
		end_test();
	endtask

	task automatic nonexistent_memory();
		logic [31:0] r;
		begin_test("nonexistent_memory");
		r = next_rand();
		mas = {2'b11, r[15:0]};
		press(0);
		check(36'd1, apr_word_pkg::word_t'(nxm));
		check(36'd0, mb);
		sw_mem_disable = 1'b1;
		key_ex = 1'b1;
		step(1);
		hold_test = 1'b1;
		step(2);
		key_ex = 1'b0;
		step(3 * apr_bus_pkg::NXM_TIMEOUT);
		hold_test = 1'b0;
		apply_reset();
		sw_mem_disable = 1'b0;
		check(36'd0, apr_word_pkg::word_t'(busy));
		end_test();
	endtask

	task automatic priority_chain();
		logic [31:0] r;
		apr_word_pkg::chan_t mask, pend, held;
		int ch;
		begin_test("priority_interrupts");
		for (int k = 0; k < 3; k++) begin
			r = next_rand();
			mask = r[6:0] | 7'h01;
			cono(1'b1, 1'b0, 1'b1, mask);
			check(apr_word_pkg::word_t'(mask), apr_word_pkg::word_t'(pio));
			iobus_pi_req = r[14:8];
			step(1);
			iobus_pi_req = '0;
			pend = r[14:8] & mask;
			ch = lowest_chan(pend);
			check(apr_word_pkg::word_t'(ch), apr_word_pkg::word_t'(pi_rq_chan));
			if (ch != 0) begin
				pi_grant = 1'b1;
				step(1);
				pi_grant = 1'b0;
				held = '0;
				held[ch] = 1'b1;
				pend[ch] = 1'b0;
				check(36'd0, apr_word_pkg::word_t'(pi_rq_chan)); // Blocks itself and below
				check(apr_word_pkg::word_t'(held), apr_word_pkg::word_t'(pih));
				pi_dismiss = 1'b1;
				step(1);
				pi_dismiss = 1'b0;
				check(apr_word_pkg::word_t'(lowest_chan(pend)),
					apr_word_pkg::word_t'(pi_rq_chan));
			end
		end
		cono(1'b1, 1'b1, 1'b0, mask);
		iobus_pi_req = '1;
		step(1);
		iobus_pi_req = '0;
		check(36'd0, apr_word_pkg::word_t'(pir));
		check(36'd0, apr_word_pkg::word_t'(pi_active));
		end_test();
	endtask

	initial begin
		repeat (WATCHDOG) @(posedge clk);
		$display("Watchdog expired after %0d cycles", WATCHDOG);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		pi_reset = 1'b1;
		{key_ex, key_ex_nxt, key_dep, key_dep_nxt, key_apr_load} = '0;
		{sw_user, sw_mem_disable, pi_grant, pi_dismiss} = '0;
		datasw = '0;
		mas = '0;
		iobus_pi_req = '0;
		pi_cono = '0;
		apply_reset();
		deposit_then_examine();
		deposit_examine_next();
		relocate_and_protect();
		fast_memory_bypass();
		nonexistent_memory();
		priority_chain();
		step(2);
		$display("%0d tests, %0d failed, %0d errors", NUM_TESTS, failed_tests, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== test/membus_model.sv ====
module membus_model (
	input  logic clk,
	input  logic pi_reset,
	input  apr_bus_pkg::membus_req_t req,
	output apr_bus_pkg::membus_rsp_t rsp
);

	localparam apr_word_pkg::addr_t POP_LIMIT = 18'o600000; // Unpopulated from here up

	apr_word_pkg::word_t mem [0:2**18-1];
	logic rq_d;
	int unsigned phase;

	// Fill pattern carries the full address in both halves
	initial begin
		for (int a = 0; a < 2**18; a++)
			mem[a] = {a[17:0], ~a[17:0]};
	end

	always @(posedge clk) begin
		if (pi_reset) begin
			rsp <= '0;
			rq_d <= 1'b0;
			phase <= 0;
		end else begin
			rq_d <= req.rq_cyc;
			rsp.addr_ack <= 1'b0;
			rsp.rd_rs <= 1'b0;
			rsp.mb_in <= '0;
			if (req.rq_cyc && !rq_d && req.addr < POP_LIMIT)
				phase <= 1;
			if (phase == 1) begin
				rsp.addr_ack <= 1'b1;
				phase <= req.rd_rq ? 2 : 0;
			end
			if (phase == 2)
				phase <= 3;
			if (phase == 3) begin
				rsp.rd_rs <= 1'b1; // Two cycles after acknowledge
				rsp.mb_in <= mem[req.addr];
				phase <= 0;
			end
			if (rsp.addr_ack && req.wr_rq)
				mem[req.addr] <= req.mb_out;
		end
	end

endmodule
